/* common/fft16_pkg.sv */
`default_nettype none

package fft16_pkg;

  // Frame geometry
  localparam int N_POINTS = 16;
  localparam int RADIX    = 4;
  localparam int IDX_W    = 4;

  // Twiddle format, Q1.14 in a 16 bit signed word
  localparam int TW_FRAC = 14;
  localparam int TW_W    = 16;

  //////////////////////////////////////////////////////////////////////
  // W16^e = exp(-j*2*pi*e/16), scaled by 2^14 and rounded
  //////////////////////////////////////////////////////////////////////

  localparam logic signed [TW_W-1:0] TW_RE [N_POINTS] = '{
     16384,  15137,  11585,   6270,
         0,  -6270, -11585, -15137,
    -16384, -15137, -11585,  -6270,
         0,   6270,  11585,  15137
  };

  localparam logic signed [TW_W-1:0] TW_IM [N_POINTS] = '{
         0,  -6270, -11585, -15137,
    -16384, -15137, -11585,  -6270,
         0,   6270,  11585,  15137,
     16384,  15137,  11585,   6270
  };

endpackage

`default_nettype wire

/* common/fft_frame_if.sv */
`timescale 1ns/1ns
`default_nettype none

// One whole frame of complex parts, qualified by a single-cycle valid
interface fft_frame_if import fft16_pkg::*; #(
  parameter int PART_W = 12
);

  logic                     valid;
  logic signed [PART_W-1:0] re [N_POINTS];
  logic signed [PART_W-1:0] im [N_POINTS];

  modport source (
    output valid,
    output re,
    output im
  );

  modport sink (
    input valid,
    input re,
    input im
  );

endinterface

`default_nettype wire

/* fft_core/radix4_butterfly.sv */
`timescale 1ns/1ns
`default_nettype none

module radix4_butterfly import fft16_pkg::*; #(
  parameter int W = 12
) (
  input  logic signed [W-1:0] a_re_i [RADIX],
  input  logic signed [W-1:0] a_im_i [RADIX],
  output logic signed [W+1:0] y_re_o [RADIX],
  output logic signed [W+1:0] y_im_o [RADIX]
);

  // Partial sums, one bit of growth
  logic signed [W:0] s02_re;
  logic signed [W:0] s02_im;
  logic signed [W:0] d02_re;
  logic signed [W:0] d02_im;
  logic signed [W:0] s13_re;
  logic signed [W:0] s13_im;
  logic signed [W:0] d13_re;
  logic signed [W:0] d13_im;

  //////////////////////////////////////////////////////////////////////
  // First level
  //////////////////////////////////////////////////////////////////////

  assign s02_re = a_re_i[0] + a_re_i[2];
  assign s02_im = a_im_i[0] + a_im_i[2];
  assign d02_re = a_re_i[0] - a_re_i[2];
  assign d02_im = a_im_i[0] - a_im_i[2];
  assign s13_re = a_re_i[1] + a_re_i[3];
  assign s13_im = a_im_i[1] + a_im_i[3];
  assign d13_re = a_re_i[1] - a_re_i[3];
  assign d13_im = a_im_i[1] - a_im_i[3];

  //////////////////////////////////////////////////////////////////////
  // Second level
  //////////////////////////////////////////////////////////////////////

  // Y0 and Y2 need no rotation
  assign y_re_o[0] = s02_re + s13_re;
  assign y_im_o[0] = s02_im + s13_im;
  assign y_re_o[2] = s02_re - s13_re;
  assign y_im_o[2] = s02_im - s13_im;

  // -j*(a1-a3) as a swap of parts with the new imaginary negated
  assign y_re_o[1] = d02_re + d13_im;
  assign y_im_o[1] = d02_im - d13_re;

  // +j*(a1-a3)
  assign y_re_o[3] = d02_re - d13_im;
  assign y_im_o[3] = d02_im + d13_re;

endmodule

`default_nettype wire

/* fft_core/twiddle_rotator.sv */
`timescale 1ns/1ns
`default_nettype none

module twiddle_rotator import fft16_pkg::*; #(
  parameter int W = 14
) (
  input  logic signed [W-1:0]   x_re_i,
  input  logic signed [W-1:0]   x_im_i,
  input  logic [IDX_W-1:0]      exp_i,
  output logic signed [W:0]     y_re_o,
  output logic signed [W:0]     y_im_o
);

  // Full precision complex product width
  localparam int PROD_W = W + TW_W + 1;

  logic signed [TW_W-1:0]   tw_re;
  logic signed [TW_W-1:0]   tw_im;
  logic signed [PROD_W-1:0] prod_re;
  logic signed [PROD_W-1:0] prod_im;
  logic signed [PROD_W-1:0] scaled_re;
  logic signed [PROD_W-1:0] scaled_im;

  //////////////////////////////////////////////////////////////////////
  // Table lookup and product
  //////////////////////////////////////////////////////////////////////

  assign tw_re = TW_RE[exp_i];
  assign tw_im = TW_IM[exp_i];

  // (xr + j*xi) * (cr + j*ci)
  assign prod_re = x_re_i * tw_re - x_im_i * tw_im;
  assign prod_im = x_re_i * tw_im + x_im_i * tw_re;

  // Drop the fraction, rounds toward minus infinity
  assign scaled_re = prod_re >>> TW_FRAC;
  assign scaled_im = prod_im >>> TW_FRAC;

  // Unit-magnitude twiddles keep the result within one extra bit
  assign y_re_o = scaled_re[W:0];
  assign y_im_o = scaled_im[W:0];

endmodule

`default_nettype wire

/* fft_core/fft_core.sv */
`timescale 1ns/1ns
`default_nettype none

module fft_core import fft16_pkg::*; #(
  parameter int IN_W = 12
) (
  input  logic        clk,
  input  logic        rst_n_i,
  fft_frame_if.sink   frame_i,
  fft_frame_if.source frame_o
);

  localparam int R1_W  = IN_W + 2;
  localparam int ROT_W = IN_W + 3;
  localparam int OUT_W = IN_W + 5;

  // Rank 1 in [n2][n1], out and registered in [n2][k1]
  logic signed [IN_W-1:0]  a1_re [RADIX][RADIX];
  logic signed [IN_W-1:0]  a1_im [RADIX][RADIX];
  logic signed [R1_W-1:0]  b1_re [RADIX][RADIX];
  logic signed [R1_W-1:0]  b1_im [RADIX][RADIX];
  logic signed [R1_W-1:0]  s1_re [RADIX][RADIX];
  logic signed [R1_W-1:0]  s1_im [RADIX][RADIX];
  // Rotated values, transposed to [k1][n2]
  logic signed [ROT_W-1:0] r_re  [RADIX][RADIX];
  logic signed [ROT_W-1:0] r_im  [RADIX][RADIX];
  logic signed [ROT_W-1:0] s2_re [RADIX][RADIX];
  logic signed [ROT_W-1:0] s2_im [RADIX][RADIX];
  // Rank 2 out in [k1][k2], then flattened to bin order
  logic signed [OUT_W-1:0] b2_re [RADIX][RADIX];
  logic signed [OUT_W-1:0] b2_im [RADIX][RADIX];
  logic signed [OUT_W-1:0] x_re  [N_POINTS];
  logic signed [OUT_W-1:0] x_im  [N_POINTS];
  logic                    v1;
  logic                    v2;

  //////////////////////////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////////////////////////

  for (genvar n2 = 0; n2 < RADIX; n2++) begin : g_rank1
    for (genvar n1 = 0; n1 < RADIX; n1++) begin : g_pick
      assign a1_re[n2][n1] = frame_i.re[RADIX*n1 + n2];
      assign a1_im[n2][n1] = frame_i.im[RADIX*n1 + n2];
    end
    radix4_butterfly #(.W(IN_W)) u_bf (
      .a_re_i (a1_re[n2]),
      .a_im_i (a1_im[n2]),
      .y_re_o (b1_re[n2]),
      .y_im_o (b1_im[n2])
    );
  end

  // Twiddle index n2*k1 never exceeds 9
  for (genvar n2 = 0; n2 < RADIX; n2++) begin : g_rot_n2
    for (genvar k1 = 0; k1 < RADIX; k1++) begin : g_rot_k1
      twiddle_rotator #(.W(R1_W)) u_rot (
        .x_re_i (s1_re[n2][k1]),
        .x_im_i (s1_im[n2][k1]),
        .exp_i  (IDX_W'(n2 * k1)),
        .y_re_o (r_re[k1][n2]),
        .y_im_o (r_im[k1][n2])
      );
    end
  end

  for (genvar k1 = 0; k1 < RADIX; k1++) begin : g_rank2
    radix4_butterfly #(.W(ROT_W)) u_bf (
      .a_re_i (s2_re[k1]),
      .a_im_i (s2_im[k1]),
      .y_re_o (b2_re[k1]),
      .y_im_o (b2_im[k1])
    );
    for (genvar k2 = 0; k2 < RADIX; k2++) begin : g_place
      assign x_re[k1 + RADIX*k2] = b2_re[k1][k2];
      assign x_im[k1 + RADIX*k2] = b2_im[k1][k2];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Pipeline registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    s1_re      <= b1_re;
    s1_im      <= b1_im;
    s2_re      <= r_re;
    s2_im      <= r_im;
    frame_o.re <= x_re;
    frame_o.im <= x_im;
  end

  // Valid follows the data, one stage per rank
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      v1            <= 1'b0;
      v2            <= 1'b0;
      frame_o.valid <= 1'b0;
    end else begin
      v1            <= frame_i.valid;
      v2            <= v1;
      frame_o.valid <= v2;
    end
  end

endmodule

`default_nettype wire

/* source/sample_deserializer.sv */
`timescale 1ns/1ns
`default_nettype none

module sample_deserializer import fft16_pkg::*; #(
  parameter int IN_W = 12
) (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   sample_valid_i,
  input  logic signed [IN_W-1:0] sample_re_i,
  input  logic signed [IN_W-1:0] sample_im_i,
  fft_frame_if.source            frame_o
);

  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(N_POINTS - 1);

  logic [IDX_W-1:0]       wr_idx;
  logic signed [IN_W-1:0] slot_re [N_POINTS];
  logic signed [IN_W-1:0] slot_im [N_POINTS];

  //////////////////////////////////////////////////////////////////////
  // Sample capture
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (sample_valid_i) begin
      slot_re[wr_idx] <= sample_re_i;
      slot_im[wr_idx] <= sample_im_i;
    end
  end

  // Index wraps 15 -> 0 by overflow
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      wr_idx        <= '0;
      frame_o.valid <= 1'b0;
    end else begin
      frame_o.valid <= sample_valid_i && (wr_idx == LAST_IDX);
      if (sample_valid_i) begin
        wr_idx <= wr_idx + 1'b1;
      end
    end
  end

  // Buffer is the frame; a new sample 0 can only land after the core has sampled it
  assign frame_o.re = slot_re;
  assign frame_o.im = slot_im;

endmodule

`default_nettype wire

/* source/bin_serializer.sv */
`timescale 1ns/1ns
`default_nettype none

module bin_serializer import fft16_pkg::*; #(
  parameter int IN_W = 12
) (
  input  logic                   clk,
  input  logic                   rst_n_i,
  fft_frame_if.sink              frame_i,
  output logic                   bin_valid_o,
  output logic signed [IN_W+4:0] bin_re_o,
  output logic signed [IN_W+4:0] bin_im_o,
  output logic                   bin_last_o
);

  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(N_POINTS - 1);

  logic signed [IN_W+4:0] bank_re [N_POINTS];
  logic signed [IN_W+4:0] bank_im [N_POINTS];
  logic                   busy;
  logic [IDX_W-1:0]       rd_idx;

  //////////////////////////////////////////////////////////////////////
  // Frame hold and read-out
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (frame_i.valid) begin
      bank_re <= frame_i.re;
      bank_im <= frame_i.im;
    end
  end

  // A new frame may land while bin 15 of the previous one is out
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      busy   <= 1'b0;
      rd_idx <= '0;
    end else if (frame_i.valid) begin
      busy   <= 1'b1;
      rd_idx <= '0;
    end else if (busy) begin
      rd_idx <= rd_idx + 1'b1;
      if (rd_idx == LAST_IDX) begin
        busy <= 1'b0;
      end
    end
  end

  assign bin_valid_o = busy;
  assign bin_re_o    = bank_re[rd_idx];
  assign bin_im_o    = bank_im[rd_idx];
  assign bin_last_o  = busy && (rd_idx == LAST_IDX);

endmodule

`default_nettype wire

/* source/fft16_top.sv */
`timescale 1ns/1ns
`default_nettype none

module fft16_top #(
  parameter int IN_W = 12
) (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   sample_valid_i,
  input  logic signed [IN_W-1:0] sample_re_i,
  input  logic signed [IN_W-1:0] sample_im_i,
  output logic                   bin_valid_o,
  output logic signed [IN_W+4:0] bin_re_o,
  output logic signed [IN_W+4:0] bin_im_o,
  output logic                   bin_last_o
);

  // Frame from the deserializer, and the finished spectrum
  fft_frame_if #(.PART_W(IN_W))     in_frame ();
  fft_frame_if #(.PART_W(IN_W + 5)) out_frame ();

  sample_deserializer #(.IN_W(IN_W)) u_deser (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .sample_valid_i (sample_valid_i),
    .sample_re_i    (sample_re_i),
    .sample_im_i    (sample_im_i),
    .frame_o        (in_frame)
  );

  // Three cycles from frame in to spectrum out
  fft_core #(.IN_W(IN_W)) u_core (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .frame_i (in_frame),
    .frame_o (out_frame)
  );

  bin_serializer #(.IN_W(IN_W)) u_ser (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .frame_i     (out_frame),
    .bin_valid_o (bin_valid_o),
    .bin_re_o    (bin_re_o),
    .bin_im_o    (bin_im_o),
    .bin_last_o  (bin_last_o)
  );

endmodule

`default_nettype wire

/* bench/fft16_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module fft16_checker import fft16_pkg::*; #(
  parameter int IN_W = 12
) (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   sample_valid_i,
  input  logic signed [IN_W-1:0] sample_re_i,
  input  logic signed [IN_W-1:0] sample_im_i,
  input  logic                   bin_valid_i,
  input  logic signed [IN_W+4:0] bin_re_i,
  input  logic signed [IN_W+4:0] bin_im_i,
  input  logic                   bin_last_i,
  input  logic                   tab_known_i,
  input  int                     tab_x0_i,
  input  int                     tab_x1_i,
  input  int                     tab_x8_i,
  output int                     value_errs_o,
  output int                     other_errs_o,
  output int                     frames_o,
  output int                     pending_o
);

  localparam int OUT_W   = IN_W + 5;
  localparam int LATENCY = 5;

  longint f_re [N_POINTS];
  longint f_im [N_POINTS];
  longint x_re [N_POINTS];
  longint x_im [N_POINTS];
  int     fill;
  int     cyc;
  // Bins still due, oldest first
  int     q_cyc [$];
  int     q_idx [$];
  longint q_re  [$];
  longint q_im  [$];
  bit     q_tab [$];
  int     q_tre [$];
  int     idx;
  logic signed [OUT_W-1:0] exp_re;
  logic signed [OUT_W-1:0] exp_im;

  initial begin
    value_errs_o = 0;
    other_errs_o = 0;
    frames_o     = 0;
    pending_o    = 0;
    fill         = 0;
    cyc          = 0;
  end

  //////////////////////////////////////////////////////////////////////
  // Integer reference model
  //////////////////////////////////////////////////////////////////////

  // 4-point DFT, term n rotated by (-j)^(n*k)
  function automatic void dft4(input longint ar [RADIX], input longint ai [RADIX],
                               output longint yr [RADIX], output longint yi [RADIX]);
    int m;
    for (int k = 0; k < RADIX; k++) begin
      yr[k] = 0;
      yi[k] = 0;
      for (int n = 0; n < RADIX; n++) begin
        m = (n * k) % RADIX;
        case (m)
          0: begin
            yr[k] += ar[n];
            yi[k] += ai[n];
          end
          1: begin
            yr[k] += ai[n];
            yi[k] -= ar[n];
          end
          2: begin
            yr[k] -= ar[n];
            yi[k] -= ai[n];
          end
          default: begin
            yr[k] -= ai[n];
            yi[k] += ar[n];
          end
        endcase
      end
    end
  endfunction

  function automatic void model_frame();
    longint ar [RADIX];
    longint ai [RADIX];
    longint yr [RADIX];
    longint yi [RADIX];
    longint rr [RADIX][RADIX];
    longint ri [RADIX][RADIX];
    longint p_re;
    longint p_im;
    int     e;
    // Rank 1 over n1, then rotation by W16^(n2*k1) with floor shift
    for (int n2 = 0; n2 < RADIX; n2++) begin
      for (int n1 = 0; n1 < RADIX; n1++) begin
        ar[n1] = f_re[RADIX*n1 + n2];
        ai[n1] = f_im[RADIX*n1 + n2];
      end
      dft4(ar, ai, yr, yi);
      for (int k1 = 0; k1 < RADIX; k1++) begin
        e    = n2 * k1;
        p_re = yr[k1] * longint'(TW_RE[e]) - yi[k1] * longint'(TW_IM[e]);
        p_im = yr[k1] * longint'(TW_IM[e]) + yi[k1] * longint'(TW_RE[e]);
        rr[k1][n2] = p_re >>> TW_FRAC;
        ri[k1][n2] = p_im >>> TW_FRAC;
      end
    end
    // Rank 2 over n2 gives bin k1 + 4*k2
    for (int k1 = 0; k1 < RADIX; k1++) begin
      for (int n2 = 0; n2 < RADIX; n2++) begin
        ar[n2] = rr[k1][n2];
        ai[n2] = ri[k1][n2];
      end
      dft4(ar, ai, yr, yi);
      for (int k2 = 0; k2 < RADIX; k2++) begin
        x_re[k1 + RADIX*k2] = yr[k2];
        x_im[k1 + RADIX*k2] = yi[k2];
      end
    end
  endfunction

  task automatic queue_frame();
    model_frame();
    for (int k = 0; k < N_POINTS; k++) begin
      q_cyc.push_back(cyc + LATENCY + k);
      q_idx.push_back(k);
      q_re.push_back(x_re[k]);
      q_im.push_back(x_im[k]);
      q_tab.push_back(tab_known_i && (k == 0 || k == 1 || k == 8));
      q_tre.push_back((k == 0) ? tab_x0_i : ((k == 1) ? tab_x1_i : tab_x8_i));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Output monitor
  //////////////////////////////////////////////////////////////////////

  task automatic compare_value(input string name, input int bin_idx,
                               input logic signed [OUT_W-1:0] exp_v,
                               input logic signed [OUT_W-1:0] act_v);
    if (act_v !== exp_v) begin
      value_errs_o = value_errs_o + 1;
      $display("[FAIL] %0t ns: %s X[%0d] expected %0d, got %0d",
               $time, name, bin_idx, exp_v, act_v);
    end
  endtask

  task automatic check_bin();
    if (q_cyc.size() > 0 && q_cyc[0] == cyc) begin
      idx    = q_idx[0];
      exp_re = OUT_W'(q_re[0]);
      exp_im = OUT_W'(q_im[0]);
      if (bin_valid_i !== 1'b1) begin
        other_errs_o = other_errs_o + 1;
        $display("%0t ns: bin X[%0d] missing, burst late, short or absent", $time, idx);
      end else begin
        compare_value("bin_re_o", idx, exp_re, bin_re_i);
        compare_value("bin_im_o", idx, exp_im, bin_im_i);
        // Directed frames are real, so the table bins have no imaginary part
        if (q_tab[0]) begin
          compare_value("bin_re_o (table)", idx, OUT_W'(q_tre[0]), bin_re_i);
          compare_value("bin_im_o (table)", idx, '0, bin_im_i);
        end
      end
      if (bin_last_i !== (idx == N_POINTS - 1)) begin
        other_errs_o = other_errs_o + 1;
        $display("%0t ns: bin_last_o is %b at bin X[%0d]", $time, bin_last_i, idx);
      end
      if (idx == N_POINTS - 1 && bin_valid_i === 1'b1 && bin_last_i === 1'b1) begin
        frames_o = frames_o + 1;
      end
      void'(q_cyc.pop_front());
      void'(q_idx.pop_front());
      void'(q_re.pop_front());
      void'(q_im.pop_front());
      void'(q_tab.pop_front());
      void'(q_tre.pop_front());
    end else if (bin_valid_i !== 1'b0 || bin_last_i !== 1'b0) begin
      other_errs_o = other_errs_o + 1;
      $display("%0t ns: bin_valid_o or bin_last_o high with no bin due (latency or burst length)",
               $time);
    end
  endtask

  // Inputs settle 2 ns after the rising edge, so the falling edge sees stable values
  always @(negedge clk) begin
    cyc = cyc + 1;
    if (!rst_n_i) begin
      fill = 0;
      if (bin_valid_i === 1'b1 || bin_last_i === 1'b1) begin
        other_errs_o = other_errs_o + 1;
        $display("%0t ns: bin_valid_o or bin_last_o high during reset", $time);
      end
    end else begin
      if (sample_valid_i === 1'b1) begin
        f_re[fill] = longint'(sample_re_i);
        f_im[fill] = longint'(sample_im_i);
        fill = fill + 1;
        if (fill == N_POINTS) begin
          queue_frame();
          fill = 0;
        end
      end
      check_bin();
    end
    pending_o = q_cyc.size() + fill;
  end

endmodule

`default_nettype wire

/* bench/tb_fft16.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_fft16;

  localparam int IN_W           = 12;
  localparam int OUT_W          = IN_W + 5;
  localparam int N_SAMPLES      = 16;
  localparam int CLK_PERIOD     = 20;
  localparam int RESET_CYCLES   = 16;
  localparam int DRIVE_DELAY    = 2;
  localparam int SEED           = 9;
  localparam int CYCLES_PER_ROW = 40;

  // Frame kinds
  localparam int KIND_IMPULSE = 0;
  localparam int KIND_CONST   = 1;
  localparam int KIND_ALT     = 2;
  localparam int KIND_RANDOM  = 3;

  logic                    clk = 1'b0;
  logic                    rst_n_i;
  logic                    sample_valid_i;
  logic signed [IN_W-1:0]  sample_re_i;
  logic signed [IN_W-1:0]  sample_im_i;
  logic                    bin_valid_o;
  logic signed [OUT_W-1:0] bin_re_o;
  logic signed [OUT_W-1:0] bin_im_o;
  logic                    bin_last_o;

  // Expected X[0], X[1], X[8] of the frame being driven
  logic tab_known;
  int   tab_x0;
  int   tab_x1;
  int   tab_x8;

  int value_errs;
  int other_errs;
  int frames_done;
  int pending;
  int bench_errs;

  // Stimulus table, one row per frame
  int          row_kind  [$];
  int          row_amp   [$];
  logic [15:0] row_gaps  [$];
  bit          row_rgap  [$];
  bit          row_known [$];
  int          row_x0    [$];
  int          row_x1    [$];
  int          row_x8    [$];
  int          n_rows;
  bit          table_ready;

  always #(CLK_PERIOD/2) clk = ~clk;

  fft16_top #(.IN_W(IN_W)) i_dut (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .sample_valid_i (sample_valid_i),
    .sample_re_i    (sample_re_i),
    .sample_im_i    (sample_im_i),
    .bin_valid_o    (bin_valid_o),
    .bin_re_o       (bin_re_o),
    .bin_im_o       (bin_im_o),
    .bin_last_o     (bin_last_o)
  );

  fft16_checker #(.IN_W(IN_W)) i_chk (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .sample_valid_i (sample_valid_i),
    .sample_re_i    (sample_re_i),
    .sample_im_i    (sample_im_i),
    .bin_valid_i    (bin_valid_o),
    .bin_re_i       (bin_re_o),
    .bin_im_i       (bin_im_o),
    .bin_last_i     (bin_last_o),
    .tab_known_i    (tab_known),
    .tab_x0_i       (tab_x0),
    .tab_x1_i       (tab_x1),
    .tab_x8_i       (tab_x8),
    .value_errs_o   (value_errs),
    .other_errs_o   (other_errs),
    .frames_o       (frames_done),
    .pending_o      (pending)
  );

  //////////////////////////////////////////////////////////////////////
  // Stimulus table
  //////////////////////////////////////////////////////////////////////

  task automatic add_row(input int kind, input int amp, input logic [15:0] gaps,
                         input bit rgap, input bit known,
                         input int x0, input int x1, input int x8);
    row_kind.push_back(kind);
    row_amp.push_back(amp);
    row_gaps.push_back(gaps);
    row_rgap.push_back(rgap);
    row_known.push_back(known);
    row_x0.push_back(x0);
    row_x1.push_back(x1);
    row_x8.push_back(x8);
  endtask

  task automatic build_table();
    // kind          amp     gaps     rand known  X[0]    X[1]    X[8]
    add_row(KIND_IMPULSE,  100, 16'h0000, 0, 1,    100,    100,    100);
    add_row(KIND_IMPULSE, -1500, 16'h0421, 0, 1,  -1500,  -1500,  -1500);
    add_row(KIND_CONST,    100, 16'h0000, 0, 1,   1600,      0,      0);
    add_row(KIND_CONST,  -2000, 16'h8001, 0, 1, -32000,      0,      0);
    add_row(KIND_ALT,       50, 16'h0000, 0, 1,      0,      0,    800);
    add_row(KIND_ALT,     2047, 16'h5555, 0, 1,      0,      0,  32752);
    add_row(KIND_RANDOM,     0, 16'h0000, 1, 0,      0,      0,      0);
    add_row(KIND_RANDOM,     0, 16'h0000, 1, 0,      0,      0,      0);
    add_row(KIND_RANDOM,     0, 16'h0000, 1, 0,      0,      0,      0);
    // Back-to-back, no gaps
    add_row(KIND_RANDOM,     0, 16'h0000, 0, 0,      0,      0,      0);
    add_row(KIND_RANDOM,     0, 16'h0000, 0, 0,      0,      0,      0);
    add_row(KIND_CONST,   2047, 16'h0000, 0, 1,  32752,      0,      0);
    add_row(KIND_IMPULSE, -2048, 16'h0000, 0, 1,  -2048,  -2048,  -2048);
    n_rows = row_kind.size();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Drive loop
  //////////////////////////////////////////////////////////////////////

  task automatic drive_sample(input logic signed [IN_W-1:0] re,
                              input logic signed [IN_W-1:0] im);
    sample_valid_i = 1'b1;
    sample_re_i    = re;
    sample_im_i    = im;
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic send_frame(input int r);
    logic [15:0] gaps;
    int          amp;
    amp       = row_amp[r];
    gaps      = row_rgap[r] ? (16'($urandom) & 16'($urandom)) : row_gaps[r];
    tab_known = row_known[r];
    tab_x0    = row_x0[r];
    tab_x1    = row_x1[r];
    tab_x8    = row_x8[r];
    for (int n = 0; n < N_SAMPLES; n++) begin
      // A set gap bit idles the input for one cycle before sample n
      if (gaps[n]) begin
        sample_valid_i = 1'b0;
        @(posedge clk);
        #DRIVE_DELAY;
      end
      case (row_kind[r])
        KIND_IMPULSE: drive_sample((n == 0) ? IN_W'(amp) : IN_W'(0), IN_W'(0));
        KIND_CONST:   drive_sample(IN_W'(amp), IN_W'(0));
        KIND_ALT:     drive_sample(IN_W'((n % 2 == 0) ? amp : -amp), IN_W'(0));
        default:      drive_sample(IN_W'($urandom), IN_W'($urandom));
      endcase
    end
    sample_valid_i = 1'b0;
  endtask

  initial begin
    void'($urandom(SEED));
    rst_n_i        = 1'b0;
    sample_valid_i = 1'b0;
    sample_re_i    = '0;
    sample_im_i    = '0;
    tab_known      = 1'b0;
    tab_x0         = 0;
    tab_x1         = 0;
    tab_x8         = 0;
    bench_errs     = 0;
    build_table();
    table_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rst_n_i = 1'b1;
    for (int r = 0; r < n_rows; r++) begin
      send_frame(r);
    end
    wait (pending == 0);
    repeat (4) @(posedge clk);
    if (frames_done != n_rows) begin
      bench_errs = bench_errs + 1;
      $display("Only %0d of %0d frames came out of the DUT", frames_done, n_rows);
    end
    $display("Errors: %0d value, %0d protocol, %0d frame count",
             value_errs, other_errs, bench_errs);
    if (value_errs + other_errs + bench_errs == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    wait (table_ready);
    repeat (n_rows * CYCLES_PER_ROW + 100) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles",
             n_rows * CYCLES_PER_ROW + 100);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* fft16.f */
common/fft16_pkg.sv
common/fft_frame_if.sv
fft_core/radix4_butterfly.sv
fft_core/twiddle_rotator.sv
fft_core/fft_core.sv
source/sample_deserializer.sv
source/bin_serializer.sv
source/fft16_top.sv
bench/fft16_checker.sv
bench/tb_fft16.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the FFT testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing -j 0 --top-module tb_fft16 \
  -f fft16.f -Mdir "$BUILD_DIR" -o tb_fft16
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/tb_fft16" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG_FILE"; then
  exit 1
fi
exit 0
